//--- Bender.yml
package:
  name: daq_core

sources:
  - include_dirs:
      - source
    files:
      - source/daq_pkg.sv
      - source/reg_bus_if.sv
      - source/bus_decoder.sv
      - source/system_regs.sv
      - source/pulse_gen.sv
      - source/edge_timestamper.sv
      - source/rr_arbiter.sv
      - source/daq_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/daq_core_checker.sv
      - dv/daq_core_tb.sv

//--- dv/daq_core_checker.sv
`timescale 1ns/1ps

module daq_core_checker (
    input logic BUS_CLK,
    input logic BUS_RST,
    input logic bus_rd,
    input logic bus_wr,
    input logic arb_ready,
    input logic arb_write,
    input logic inj_pulse
);

    // Number of failed assertions
    int fail_count = 0;

    // Stream strobe quiet through reset and the first cycle after it
    a_write_after_reset: assert property (@(posedge BUS_CLK) BUS_RST |=> !arb_write)
        else begin
            fail_count++;
            $error("arb_write high during or right after reset");
        end

    // Every output word follows a ready cycle
    a_write_needs_ready: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        arb_write |-> $past(arb_ready))
        else begin
            fail_count++;
            $error("arb_write without arb_ready in the previous cycle");
        end

    a_no_rd_wr: assert property (@(posedge BUS_CLK) !(bus_rd && bus_wr))
        else begin
            fail_count++;
            $error("bus_rd and bus_wr high together");
        end

    // Pulser output held low in reset
    a_pulse_in_reset: assert property (@(posedge BUS_CLK) BUS_RST ##1 BUS_RST |-> !inj_pulse)
        else begin
            fail_count++;
            $error("inj_pulse high while BUS_RST high");
        end

endmodule

bind daq_core daq_core_checker checker0 (
    .BUS_CLK   (BUS_CLK),
    .BUS_RST   (BUS_RST),
    .bus_rd    (bus_rd),
    .bus_wr    (bus_wr),
    .arb_ready (arb_ready),
    .arb_write (arb_write),
    .inj_pulse (inj_pulse)
);

//--- dv/daq_core_tb.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module daq_core_tb import daq_pkg::*; ();

    typedef logic [31:0] word_q_t [$];

    localparam int CLK_PERIOD    = 10;
    localparam int STREAM_CYCLES = 200;
    localparam int LOSS_EDGES    = 10;
    // Cycle budget of reset, identity, GPIO, soft pulse, trigger, stream and loss tests
    localparam int TEST_CYCLES   = 10 + 40 + 30 + 220 + 130 + 380 + 130;
    localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLK_PERIOD;

    logic        BUS_CLK;
    logic        BUS_RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_wr_data;
    logic [7:0]  bus_rd_data;
    logic        bus_rd;
    logic        bus_wr;
    logic        trig_in;
    logic        inj_loop_in;
    logic        hitor_in;
    logic        inj_pulse;
    logic        resetb_ext;
    logic [4:0]  led;
    logic        arb_ready;
    logic        arb_write;
    logic [31:0] arb_data;

    string     test_name = "reset";
    int        cycle;
    word_q_t   exp_inj;
    word_q_t   exp_hor;
    daq_word_t rx_word;

    daq_core dut0 (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    // Mirrors the system timestamp, zero while in reset
    always @(posedge BUS_CLK) begin
        if (BUS_RST)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %0h actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Expected stream words of one source, stamp is change cycle plus 2
    function automatic word_q_t expected_words(input int edge_cyc[$], input logic [3:0] edge_id[$],
                                               input logic [3:0] src_id);
        word_q_t words;
        words = {};
        foreach (edge_cyc[i])
            if (edge_id[i] == src_id)
                words.push_back({src_id, `TS_WIDTH'(edge_cyc[i] + 2)});
        return words;
    endfunction

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_wr_data <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    // Data sampled one cycle after the strobe
    task automatic read_expect(input logic [15:0] addr, input logic [7:0] expected);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(posedge BUS_CLK);
        check_value($sformatf("%s read %h", test_name, addr), expected, bus_rd_data);
    endtask

    task automatic send_trigger;
        @(posedge BUS_CLK);
        trig_in <= 1'b1;
        @(posedge BUS_CLK);
        trig_in <= 1'b0;
    endtask

    // Rise is counted in cycles after the start edge
    task automatic measure_pulse(input int window, output int rise, output int high,
                                 output int count);
        logic prev;
        rise  = -1;
        high  = 0;
        count = 0;
        prev  = 1'b0;
        for (int k = 1; k <= window; k++) begin
            @(posedge BUS_CLK);
            if (inj_pulse) begin
                if (rise < 0)
                    rise = k - 1;
                high++;
                if (!prev)
                    count++;
            end
            prev = inj_pulse;
        end
    endtask

    task automatic check_pulse(input int dly, input int wid, input int rise, input int high,
                               input int count);
        check_value({test_name, " rise"}, (wid == 0) ? -1 : dly + 1, rise);
        check_value({test_name, " width"}, wid, high);
        check_value({test_name, " count"}, (wid == 0) ? 0 : 1, count);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_inj.size() != 0 || exp_hor.size() != 0) && n < limit) begin
            @(posedge BUS_CLK);
            n++;
        end
        if (exp_inj.size() != 0 || exp_hor.size() != 0)
            fail_run($sformatf("%s: stream words still missing after %0d cycles", test_name, n));
        // Room for any extra word to show up
        repeat (5) @(posedge BUS_CLK);
    endtask

    // Each output word checked against the head of its source queue
    always @(posedge BUS_CLK) begin
        if (!BUS_RST && arb_write) begin
            rx_word.raw = arb_data;
            if (rx_word.stamp.id == `ID_TS_INJ) begin
                if (exp_inj.size() == 0)
                    fail_run($sformatf("%s: unexpected injection word %h", test_name, arb_data));
                else
                    check_value({test_name, " inj word"}, exp_inj.pop_front(), rx_word.raw);
            end else if (rx_word.stamp.id == `ID_TS_HOR) begin
                if (exp_hor.size() == 0)
                    fail_run($sformatf("%s: unexpected hit-or word %h", test_name, arb_data));
                else
                    check_value({test_name, " hor word"}, exp_hor.pop_front(), rx_word.raw);
            end else begin
                fail_run($sformatf("%s: word %h carries an unknown id", test_name, arb_data));
            end
        end
    end

    always @(posedge BUS_CLK) begin
        if (dut0.checker0.fail_count != 0)
            fail_run("protocol assertion failed in the checker");
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all tests finished");
    end

    initial begin
        int          dly;
        int          wid;
        int          rise;
        int          high;
        int          count;
        int          base;
        logic [7:0]  gpio_val;
        bit          inj_pat [STREAM_CYCLES];
        bit          hor_pat [STREAM_CYCLES];
        int          edge_cyc [$];
        logic [3:0]  edge_id [$];
        word_q_t     all_words;

        void'($urandom(32'hab66f6d6));
        BUS_RST     = 1'b1;
        bus_add     = 16'h0000;
        bus_wr_data = 8'h00;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        trig_in     = 1'b0;
        inj_loop_in = 1'b0;
        hitor_in    = 1'b0;
        arb_ready   = 1'b1;
        repeat (8) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;

        // GPIO outputs at reset values before any write
        test_name = "gpio_reset";
        check_value({test_name, " led"}, 0, led);
        check_value({test_name, " resetb"}, 1, resetb_ext);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_GPIO, 8'h00);

        test_name = "identity";
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_VERSION, `MODULE_VERSION);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_MINOR, `FW_VERSION_MINOR);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_MAJOR, `FW_VERSION_MAJOR);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_BOARD, `BOARD_ID);
        bus_write(`DAQ_SYS_BASEADDR + `SYS_REG_CONFIGURED_WR, 8'h01);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_CONFIGURED, 8'h01);
        // Gap between blocks
        read_expect(16'h0500, 8'h00);

        test_name = "gpio";
        gpio_val = 8'($urandom_range(255));
        bus_write(`DAQ_SYS_BASEADDR + `SYS_REG_GPIO, gpio_val);
        read_expect(`DAQ_SYS_BASEADDR + `SYS_REG_GPIO, gpio_val);
        check_value({test_name, " led"}, gpio_val[5:1], led);
        check_value({test_name, " resetb"}, !gpio_val[0], resetb_ext);

        // First round forces zero width
        test_name = "soft_pulse";
        for (int i = 0; i < 4; i++) begin
            dly = $urandom_range(20, 1);
            wid = (i == 0) ? 0 : $urandom_range(10, 0);
            bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_DELAY, 8'(dly));
            bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_WIDTH, 8'(wid));
            bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_START, 8'h00);
            measure_pulse(dly + wid + 8, rise, high, count);
            check_pulse(dly, wid, rise, high, count);
            read_expect(`PULSE_INJ_BASEADDR + `PULSE_REG_START, 8'h01);
        end

        test_name = "trig_off";
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_CTRL, 8'h00);
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_DELAY, 8'd3);
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_WIDTH, 8'd4);
        send_trigger();
        measure_pulse(15, rise, high, count);
        check_value({test_name, " count"}, 0, count);

        // Second strobe lands while the first sequence is busy
        test_name = "trig_on";
        dly = $urandom_range(20, 1);
        wid = $urandom_range(10, 1);
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_CTRL, 8'h01);
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_DELAY, 8'(dly));
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_WIDTH, 8'(wid));
        fork
            begin
                send_trigger();
                measure_pulse(dly + wid + 8, rise, high, count);
            end
            begin
                repeat (2) @(posedge BUS_CLK);
                send_trigger();
            end
        join
        check_pulse(dly, wid, rise, high, count);
        bus_write(`PULSE_INJ_BASEADDR + `PULSE_REG_CTRL, 8'h00);

        test_name = "stream";
        bus_write(`TS_INJ_BASEADDR + `TS_REG_ENABLE, 8'h01);
        bus_write(`TS_HOR_BASEADDR + `TS_REG_ENABLE, 8'h01);
        // Single-cycle highs, never back to back
        for (int k = 0; k < STREAM_CYCLES; k++) begin
            inj_pat[k] = (k > 0 && inj_pat[k-1]) ? 1'b0 : ($urandom_range(2) == 0);
            hor_pat[k] = (k > 0 && hor_pat[k-1]) ? 1'b0 : ($urandom_range(2) == 0);
        end
        @(posedge BUS_CLK);
        base = cycle;
        edge_cyc.delete();
        edge_id.delete();
        for (int k = 0; k < STREAM_CYCLES; k++) begin
            if (inj_pat[k]) begin
                edge_cyc.push_back(base + k + 1);
                edge_id.push_back(`ID_TS_INJ);
            end
            if (hor_pat[k]) begin
                edge_cyc.push_back(base + k + 1);
                edge_id.push_back(`ID_TS_HOR);
            end
        end
        exp_inj = expected_words(edge_cyc, edge_id, `ID_TS_INJ);
        exp_hor = expected_words(edge_cyc, edge_id, `ID_TS_HOR);
        for (int k = 0; k < STREAM_CYCLES; k++) begin
            if (k > 0)
                @(posedge BUS_CLK);
            inj_loop_in <= inj_pat[k];
            hitor_in    <= hor_pat[k];
        end
        @(posedge BUS_CLK);
        inj_loop_in <= 1'b0;
        hitor_in    <= 1'b0;
        wait_drained(64);

        // Ten edges into an eight-deep FIFO with the sink stalled
        test_name = "loss";
        @(posedge BUS_CLK);
        arb_ready <= 1'b0;
        base = cycle + 1;
        edge_cyc.delete();
        edge_id.delete();
        for (int k = 0; k < LOSS_EDGES; k++) begin
            edge_cyc.push_back(base + 2 * k + 1);
            edge_id.push_back(`ID_TS_HOR);
        end
        all_words = expected_words(edge_cyc, edge_id, `ID_TS_HOR);
        exp_hor   = all_words[0:`TS_FIFO_DEPTH-1];
        for (int k = 0; k < 2 * LOSS_EDGES; k++) begin
            @(posedge BUS_CLK);
            hitor_in <= (k % 2 == 0);
        end
        @(posedge BUS_CLK);
        hitor_in <= 1'b0;
        repeat (4) @(posedge BUS_CLK);
        read_expect(`TS_HOR_BASEADDR + `TS_REG_LOST, 8'd2);
        @(posedge BUS_CLK);
        arb_ready <= 1'b1;
        wait_drained(40);
        bus_write(`TS_HOR_BASEADDR + `TS_REG_LOST, 8'h00);
        read_expect(`TS_HOR_BASEADDR + `TS_REG_LOST, 8'h00);

        repeat (4) @(posedge BUS_CLK);
        if (dut0.checker0.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("protocol checker reported assertion failures");
            $display("sim failed");
            $fatal(1, "run stopped");
        end
    end

endmodule

//--- source/bus_decoder.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module bus_decoder (
    input  logic        BUS_CLK,
    input  logic        BUS_RST,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_wr_data,
    input  logic        bus_rd,
    input  logic        bus_wr,
    output logic [7:0]  bus_rd_data,
    reg_bus_if.decoder  sys_bus,
    reg_bus_if.decoder  pulse_bus,
    reg_bus_if.decoder  ts_inj_bus,
    reg_bus_if.decoder  ts_hor_bus
);

    logic sel_sys;
    logic sel_pulse;
    logic sel_ts_inj;
    logic sel_ts_hor;

    // Range match per block
    assign sel_sys    = (bus_add >= `DAQ_SYS_BASEADDR) && (bus_add <= `DAQ_SYS_HIGHADDR);
    assign sel_pulse  = (bus_add >= `PULSE_INJ_BASEADDR) && (bus_add <= `PULSE_INJ_HIGHADDR);
    assign sel_ts_inj = (bus_add >= `TS_INJ_BASEADDR) && (bus_add <= `TS_INJ_HIGHADDR);
    assign sel_ts_hor = (bus_add >= `TS_HOR_BASEADDR) && (bus_add <= `TS_HOR_HIGHADDR);

    // Strobes gated by the match
    assign sys_bus.rd    = bus_rd & sel_sys;
    assign sys_bus.wr    = bus_wr & sel_sys;
    assign pulse_bus.rd  = bus_rd & sel_pulse;
    assign pulse_bus.wr  = bus_wr & sel_pulse;
    assign ts_inj_bus.rd = bus_rd & sel_ts_inj;
    assign ts_inj_bus.wr = bus_wr & sel_ts_inj;
    assign ts_hor_bus.rd = bus_rd & sel_ts_hor;
    assign ts_hor_bus.wr = bus_wr & sel_ts_hor;

    // Low address bits and write data shared by all blocks
    assign sys_bus.offset    = bus_add[`BLOCK_OFFSET_WIDTH-1:0];
    assign pulse_bus.offset  = bus_add[`BLOCK_OFFSET_WIDTH-1:0];
    assign ts_inj_bus.offset = bus_add[`BLOCK_OFFSET_WIDTH-1:0];
    assign ts_hor_bus.offset = bus_add[`BLOCK_OFFSET_WIDTH-1:0];
    assign sys_bus.wdata     = bus_wr_data;
    assign pulse_bus.wdata   = bus_wr_data;
    assign ts_inj_bus.wdata  = bus_wr_data;
    assign ts_hor_bus.wdata  = bus_wr_data;

    // Read data one cycle after the strobe, held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            bus_rd_data <= 8'h00;
        end else if (bus_rd) begin
            if (sel_sys)
                bus_rd_data <= sys_bus.rdata;
            else if (sel_pulse)
                bus_rd_data <= pulse_bus.rdata;
            else if (sel_ts_inj)
                bus_rd_data <= ts_inj_bus.rdata;
            else if (sel_ts_hor)
                bus_rd_data <= ts_hor_bus.rdata;
            else
                // Unmapped address
                bus_rd_data <= 8'h00;
        end
    end

endmodule

//--- source/daq_core.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module daq_core import daq_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        BUS_RST,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_wr_data,
    output logic [7:0]  bus_rd_data,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  logic        trig_in,
    input  logic        inj_loop_in,
    input  logic        hitor_in,
    output logic        inj_pulse,
    output logic        resetb_ext,
    output logic [4:0]  led,
    input  logic        arb_ready,
    output logic        arb_write,
    output logic [31:0] arb_data
);

    // Source 0 is injection loopback, source 1 is hit-OR
    logic [`TS_WIDTH-1:0] ts_now;
    logic [1:0]           src_empty;
    logic [1:0]           src_read;
    daq_word_t            src_data [2];

    reg_bus_if sys_bus ();
    reg_bus_if pulse_bus ();
    reg_bus_if ts_inj_bus ();
    reg_bus_if ts_hor_bus ();

    bus_decoder bus_decoder0 (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .bus_add     (bus_add),
        .bus_wr_data (bus_wr_data),
        .bus_rd      (bus_rd),
        .bus_wr      (bus_wr),
        .bus_rd_data (bus_rd_data),
        .sys_bus     (sys_bus.decoder),
        .pulse_bus   (pulse_bus.decoder),
        .ts_inj_bus  (ts_inj_bus.decoder),
        .ts_hor_bus  (ts_hor_bus.decoder)
    );

    system_regs system_regs0 (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .regs       (sys_bus.block),
        .ts_now     (ts_now),
        .resetb_ext (resetb_ext),
        .led        (led)
    );

    // Injection pulser
    pulse_gen pulse_inj (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .regs    (pulse_bus.block),
        .trig_in (trig_in),
        .pulse   (inj_pulse)
    );

    edge_timestamper #(.IDENTIFIER(`ID_TS_INJ)) ts_inj (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .regs       (ts_inj_bus.block),
        .di         (inj_loop_in),
        .ts_now     (ts_now),
        .fifo_read  (src_read[0]),
        .fifo_empty (src_empty[0]),
        .fifo_data  (src_data[0])
    );

    edge_timestamper #(.IDENTIFIER(`ID_TS_HOR)) ts_hor (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .regs       (ts_hor_bus.block),
        .di         (hitor_in),
        .ts_now     (ts_now),
        .fifo_read  (src_read[1]),
        .fifo_empty (src_empty[1]),
        .fifo_data  (src_data[1])
    );

    rr_arbiter #(.NUM_SOURCES(2)) rr_arbiter0 (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .src_empty (src_empty),
        .src_data  (src_data),
        .src_read  (src_read),
        .arb_ready (arb_ready),
        .arb_write (arb_write),
        .arb_data  (arb_data)
    );

endmodule

//--- source/daq_defs.svh
`ifndef DAQ_DEFS_SVH
`define DAQ_DEFS_SVH

// Register block address ranges on the 16-bit bus
`define DAQ_SYS_BASEADDR   16'h0300
`define DAQ_SYS_HIGHADDR   16'h03FF
`define PULSE_INJ_BASEADDR 16'h0100
`define PULSE_INJ_HIGHADDR 16'h01FF
`define TS_INJ_BASEADDR    16'h0700
`define TS_INJ_HIGHADDR    16'h07FF
`define TS_HOR_BASEADDR    16'h0900
`define TS_HOR_HIGHADDR    16'h09FF

// Offset bits handed to each block
`define BLOCK_OFFSET_WIDTH 8

// Identity readback
`define MODULE_VERSION   8'd1
`define FW_VERSION_MINOR 8'd0
`define FW_VERSION_MAJOR 8'd1
`define BOARD_ID         8'd0

// System block offsets
`define SYS_REG_VERSION       8'd0
`define SYS_REG_MINOR         8'd1
`define SYS_REG_MAJOR         8'd2
`define SYS_REG_BOARD         8'd3
`define SYS_REG_CONFIGURED    8'd4
`define SYS_REG_CONFIGURED_WR 8'd5
`define SYS_REG_GPIO          8'd8
// First of four timestamp bytes, LSB first
`define SYS_REG_TIMESTAMP     8'd12

// Pulse generator offsets
`define PULSE_REG_START 8'd0
`define PULSE_REG_DELAY 8'd1
`define PULSE_REG_WIDTH 8'd2
`define PULSE_REG_CTRL  8'd3

// Timestamper offsets
`define TS_REG_ENABLE 8'd0
`define TS_REG_LOST   8'd1

// Timestamp field and per-source FIFO size
`define TS_WIDTH      28
`define TS_FIFO_DEPTH 8

// Stream source identifiers
`define ID_TS_INJ 4'b0110
`define ID_TS_HOR 4'b0010

`endif

//--- source/daq_pkg.sv
`include "daq_defs.svh"

package daq_pkg;

    // Timestamper word layout, id in the top nibble
    typedef struct packed {
        logic [3:0]           id;
        logic [`TS_WIDTH-1:0] ts;
    } ts_word_t;

    // Stream word seen either as raw bits or as id plus timestamp
    typedef union packed {
        logic [31:0] raw;
        ts_word_t    stamp;
    } daq_word_t;

endpackage

//--- source/edge_timestamper.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module edge_timestamper import daq_pkg::*; #(
    parameter logic [3:0] IDENTIFIER = 4'b0000
) (
    input  logic                 BUS_CLK,
    input  logic                 BUS_RST,
    reg_bus_if.block             regs,
    input  logic                 di,
    input  logic [`TS_WIDTH-1:0] ts_now,
    input  logic                 fifo_read,
    output logic                 fifo_empty,
    output daq_word_t            fifo_data
);

    localparam int AW = $clog2(`TS_FIFO_DEPTH);

    logic [1:0]    di_sync;
    logic          di_prev;
    logic          rise;
    logic          enable;
    logic [7:0]    lost;
    daq_word_t     push_word;
    daq_word_t     mem [`TS_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          push;
    logic          pop;

    // Two-flop input sampling then edge flop
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            di_sync <= 2'b00;
            di_prev <= 1'b0;
        end else begin
            di_sync <= {di_sync[0], di};
            di_prev <= di_sync[1];
        end
    end

    assign rise = di_sync[1] & ~di_prev;

    // Word stamped with the current system time
    always_comb begin
        push_word.stamp.id = IDENTIFIER;
        push_word.stamp.ts = ts_now;
    end

    assign full       = (count == (AW + 1)'(`TS_FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign push       = rise & enable & ~full;
    assign pop        = fifo_read & ~fifo_empty;
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

    // FIFO pointers and fill level
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Enable bit and saturating lost counter
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            enable <= 1'b0;
            lost   <= 8'h00;
        end else begin
            if (regs.wr && regs.offset == `TS_REG_ENABLE)
                enable <= regs.wdata[0];
            // Clear on any write wins over a new loss
            if (regs.wr && regs.offset == `TS_REG_LOST)
                lost <= 8'h00;
            else if (rise && enable && full && lost != 8'hFF)
                lost <= lost + 8'd1;
        end
    end

    always_comb begin
        case (regs.offset)
            `TS_REG_ENABLE: regs.rdata = {7'b0, enable};
            `TS_REG_LOST:   regs.rdata = lost;
            default:        regs.rdata = 8'h00;
        endcase
    end

endmodule

//--- source/pulse_gen.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module pulse_gen (
    input  logic     BUS_CLK,
    input  logic     BUS_RST,
    reg_bus_if.block regs,
    input  logic     trig_in,
    output logic     pulse
);

    // Sequence states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DELAY = 2'd1;
    localparam logic [1:0] ST_HIGH  = 2'd2;

    logic [7:0] delay;
    logic [7:0] width;
    logic       ext_en;
    logic [1:0] state;
    logic [7:0] cnt;
    logic       start;

    // Software start or enabled external trigger
    assign start = (regs.wr && regs.offset == `PULSE_REG_START) || (trig_in && ext_en);

    // Configuration registers
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            delay  <= 8'h00;
            width  <= 8'h00;
            ext_en <= 1'b0;
        end else if (regs.wr) begin
            if (regs.offset == `PULSE_REG_DELAY)
                delay <= regs.wdata;
            if (regs.offset == `PULSE_REG_WIDTH)
                width <= regs.wdata;
            if (regs.offset == `PULSE_REG_CTRL)
                ext_en <= regs.wdata[0];
        end
    end

    // Idle, count DELAY, rise, count WIDTH, fall
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state <= ST_IDLE;
            cnt   <= 8'h00;
            pulse <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Zero width never leaves idle
                    if (start && width != 8'h00) begin
                        state <= ST_DELAY;
                        cnt   <= delay;
                    end
                end
                ST_DELAY: begin
                    if (cnt == 8'h00) begin
                        state <= ST_HIGH;
                        pulse <= 1'b1;
                        cnt   <= width - 8'd1;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                ST_HIGH: begin
                    if (cnt == 8'h00) begin
                        state <= ST_IDLE;
                        pulse <= 1'b0;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    pulse <= 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        case (regs.offset)
            // Bit 0 reads as ready
            `PULSE_REG_START: regs.rdata = {7'b0, state == ST_IDLE};
            `PULSE_REG_DELAY: regs.rdata = delay;
            `PULSE_REG_WIDTH: regs.rdata = width;
            `PULSE_REG_CTRL:  regs.rdata = {7'b0, ext_en};
            default:          regs.rdata = 8'h00;
        endcase
    end

endmodule

//--- source/reg_bus_if.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

interface reg_bus_if;

    // Strobes already qualified by the block's address range
    logic                           rd;
    logic                           wr;
    logic [`BLOCK_OFFSET_WIDTH-1:0] offset;
    logic [7:0]                     wdata;
    // Combinational readback from the block
    logic [7:0]                     rdata;

    modport decoder (output rd, output wr, output offset, output wdata, input rdata);
    modport block (input rd, input wr, input offset, input wdata, output rdata);

endinterface

//--- source/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter import daq_pkg::*; #(
    parameter int NUM_SOURCES = 2
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic [NUM_SOURCES-1:0] src_empty,
    input  daq_word_t              src_data [NUM_SOURCES],
    output logic [NUM_SOURCES-1:0] src_read,
    input  logic                   arb_ready,
    output logic                   arb_write,
    output logic [31:0]            arb_data
);

    localparam int IW = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1;

    logic [IW-1:0] last;
    logic [IW-1:0] pick;
    logic          found;
    logic          pop;

    // First non-empty source after the last one served
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = '0;
        for (int i = 1; i <= NUM_SOURCES; i++) begin
            cand = int'(last) + i;
            if (cand >= NUM_SOURCES)
                cand = cand - NUM_SOURCES;
            if (!found && !src_empty[cand]) begin
                found = 1'b1;
                pick  = IW'(cand);
            end
        end
    end

    // Pop only while the sink is ready
    assign pop      = found & arb_ready;
    assign src_read = pop ? (NUM_SOURCES'(1) << pick) : '0;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            // Source 0 gets the first grant
            last      <= IW'(NUM_SOURCES - 1);
            arb_write <= 1'b0;
        end else begin
            arb_write <= pop;
            if (pop)
                last <= pick;
        end
    end

    // Word registered one cycle behind the pop
    always_ff @(posedge BUS_CLK) begin
        if (pop)
            arb_data <= src_data[pick].raw;
    end

endmodule

//--- source/system_regs.sv
`timescale 1ns/1ps
`include "daq_defs.svh"

module system_regs (
    input  logic                 BUS_CLK,
    input  logic                 BUS_RST,
    reg_bus_if.block             regs,
    output logic [`TS_WIDTH-1:0] ts_now,
    output logic                 resetb_ext,
    output logic [4:0]           led
);

    logic                 configured;
    logic [7:0]           gpio;
    logic [`TS_WIDTH-1:0] ts_snap;

    // Free-running system timestamp
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            ts_now <= '0;
        else
            ts_now <= ts_now + 1'b1;
    end

    // Control registers
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            configured <= 1'b0;
            gpio       <= 8'h00;
        end else if (regs.wr) begin
            if (regs.offset == `SYS_REG_CONFIGURED_WR)
                configured <= regs.wdata[0];
            if (regs.offset == `SYS_REG_GPIO)
                gpio <= regs.wdata;
        end
    end

    // Low byte read freezes the full counter for the upper bytes
    always_ff @(posedge BUS_CLK) begin
        if (regs.rd && regs.offset == `SYS_REG_TIMESTAMP)
            ts_snap <= ts_now;
    end

    // GPIO bit 0 is an active-high chip reset
    assign resetb_ext = ~gpio[0];
    assign led        = gpio[5:1];

    always_comb begin
        case (regs.offset)
            `SYS_REG_VERSION:            regs.rdata = `MODULE_VERSION;
            `SYS_REG_MINOR:              regs.rdata = `FW_VERSION_MINOR;
            `SYS_REG_MAJOR:              regs.rdata = `FW_VERSION_MAJOR;
            `SYS_REG_BOARD:              regs.rdata = `BOARD_ID;
            `SYS_REG_CONFIGURED:         regs.rdata = {7'b0, configured};
            `SYS_REG_GPIO:               regs.rdata = gpio;
            // Live byte equals what the snapshot captures in this cycle
            `SYS_REG_TIMESTAMP:          regs.rdata = ts_now[7:0];
            `SYS_REG_TIMESTAMP + 8'd1:   regs.rdata = ts_snap[15:8];
            `SYS_REG_TIMESTAMP + 8'd2:   regs.rdata = ts_snap[23:16];
            `SYS_REG_TIMESTAMP + 8'd3:   regs.rdata = {4'b0, ts_snap[27:24]};
            default:                     regs.rdata = 8'h00;
        endcase
    end

endmodule

//--- src.f
+incdir+source
source/daq_pkg.sv
source/reg_bus_if.sv
source/bus_decoder.sv
source/system_regs.sv
source/pulse_gen.sv
source/edge_timestamper.sv
source/rr_arbiter.sv
source/daq_core.sv
dv/daq_core_checker.sv
dv/daq_core_tb.sv
